// ==== cmd_pkg.sv ====
// Command format definitions for the rasterizer front end.
// Covers the opcode encoding, the field layout of a command word,
// the count types and the states of the command parser.

`default_nettype none

package cmd_pkg;

    // Opcodes in bits 31 to 28 of a command word
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_STORE  = 4'd1,
        OP_LOAD   = 4'd2,
        OP_MEMSET = 4'd3,
        OP_STREAM = 4'd4
    } opcode_t;

    // Field layout of a command word
    localparam int OP_POS   = 28;
    localparam int OP_SIZE  = 4;
    localparam int IMM_POS  = 0;
    localparam int IMM_SIZE = 28;

    // Byte-address bits inside one 32-bit word
    localparam int BEAT_SHIFT = 2;

    // Immediate byte count as carried in the command
    typedef logic [IMM_SIZE-1:0] byte_count_t;

    // Words still to produce, the byte count without its low bits
    typedef logic [IMM_SIZE-BEAT_SHIFT-1:0] beat_count_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMMAND,
        ST_STREAM,
        ST_FILL_WORD,
        ST_MEMSET
    } parser_state_t;

endpackage

`default_nettype wire

// ==== cmd_stream_top.sv ====
// Command stream front end of the rasterizer.
// Command words enter on the slave stream, the parser expands them
// into payload words, a FIFO buffers those and the unpacker sends them
// out as RGB565 pixels on the master stream.

`timescale 1ns/1ps
`default_nettype none

module cmd_stream_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic               aclk,
    input  wire logic               resetn,

    input  wire logic               s_axis_tvalid,
    output logic                    s_axis_tready,
    input  wire stream_pkg::word_t  s_axis_tdata,

    output logic                    m_axis_tvalid,
    input  wire logic               m_axis_tready,
    output stream_pkg::pixel_t      m_axis_tdata,
    output logic                    m_axis_tlast
);

    logic              fifo_in_valid;
    logic              fifo_in_ready;
    stream_pkg::word_t fifo_in_word;
    logic              fifo_in_last;

    logic              fifo_out_valid;
    logic              fifo_out_ready;
    stream_pkg::word_t fifo_out_word;
    logic              fifo_out_last;

    command_parser u_parser (
        .aclk          (aclk),
        .resetn        (resetn),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tdata  (s_axis_tdata),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready),
        .fifo_in_word  (fifo_in_word),
        .fifo_in_last  (fifo_in_last)
    );

    stream_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .aclk      (aclk),
        .resetn    (resetn),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .in_word   (fifo_in_word),
        .in_last   (fifo_in_last),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready),
        .out_word  (fifo_out_word),
        .out_last  (fifo_out_last)
    );

    pixel_unpacker u_unpacker (
        .aclk          (aclk),
        .resetn        (resetn),
        .word_valid    (fifo_out_valid),
        .word_ready    (fifo_out_ready),
        .word_data     (fifo_out_word),
        .word_last     (fifo_out_last),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule

`default_nettype wire

// ==== command_parser.sv ====
// Command parser of the rasterizer front end.
// Reads command words from the input stream and produces payload words
// (STREAM) or repeated fill words (MEMSET) on its output. The last word
// of each command is tagged. NOP, STORE, LOAD and unknown opcodes are
// dropped, as is any command with a byte count below 4.

`timescale 1ns/1ps
`default_nettype none

module command_parser (
    input  wire logic              aclk,
    input  wire logic              resetn,

    input  wire logic              s_axis_tvalid,
    output logic                   s_axis_tready,
    input  wire stream_pkg::word_t s_axis_tdata,

    output logic                   fifo_in_valid,
    input  wire logic              fifo_in_ready,
    output stream_pkg::word_t      fifo_in_word,
    output logic                   fifo_in_last
);

    cmd_pkg::parser_state_t state;
    cmd_pkg::beat_count_t   counter;
    stream_pkg::word_t      fill_q;

    cmd_pkg::opcode_t       cmd_op;
    cmd_pkg::byte_count_t   cmd_bytes;
    cmd_pkg::beat_count_t   cmd_beats;

    logic in_fire;
    logic out_free;
    logic load_stream;
    logic load_fill;

    assign cmd_op    = cmd_pkg::opcode_t'(s_axis_tdata[cmd_pkg::OP_POS +: cmd_pkg::OP_SIZE]);
    assign cmd_bytes = s_axis_tdata[cmd_pkg::IMM_POS +: cmd_pkg::IMM_SIZE];
    assign cmd_beats = cmd_pkg::beat_count_t'(cmd_bytes >> cmd_pkg::BEAT_SHIFT);

    // The output register can take a word when it is empty or draining
    assign out_free = !fifo_in_valid || fifo_in_ready;
    assign in_fire  = s_axis_tvalid && s_axis_tready;

    assign load_stream = (state == cmd_pkg::ST_STREAM) && in_fire;
    assign load_fill   = (state == cmd_pkg::ST_MEMSET) && out_free;

    // Payload is only accepted when the output register has room for it,
    // which also lets an empty register preload while the FIFO is full
    always_comb
    begin
        case (state)
            cmd_pkg::ST_COMMAND:   s_axis_tready = 1'b1;
            cmd_pkg::ST_FILL_WORD: s_axis_tready = 1'b1;
            cmd_pkg::ST_STREAM:    s_axis_tready = out_free;
            default:               s_axis_tready = 1'b0;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state         <= cmd_pkg::ST_IDLE;
            counter       <= '0;
            fifo_in_valid <= 1'b0;
        end
        else
        begin
            if (load_stream || load_fill)
            begin
                fifo_in_valid <= 1'b1;
                counter       <= counter - 1'b1;
            end
            else if (fifo_in_ready)
            begin
                fifo_in_valid <= 1'b0;
            end

            case (state)
                cmd_pkg::ST_IDLE:
                begin
                    state <= cmd_pkg::ST_COMMAND;
                end
                cmd_pkg::ST_COMMAND:
                begin
                    if (s_axis_tvalid)
                    begin
                        counter <= cmd_beats;
                        if (cmd_beats == '0)
                            state <= cmd_pkg::ST_IDLE;
                        else if (cmd_op == cmd_pkg::OP_STREAM)
                            state <= cmd_pkg::ST_STREAM;
                        else if (cmd_op == cmd_pkg::OP_MEMSET)
                            state <= cmd_pkg::ST_FILL_WORD;
                        else
                            state <= cmd_pkg::ST_IDLE;
                    end
                end
                cmd_pkg::ST_STREAM:
                begin
                    if (load_stream && counter == 1)
                        state <= cmd_pkg::ST_IDLE;
                end
                cmd_pkg::ST_FILL_WORD:
                begin
                    if (s_axis_tvalid)
                        state <= cmd_pkg::ST_MEMSET;
                end
                cmd_pkg::ST_MEMSET:
                begin
                    if (load_fill && counter == 1)
                        state <= cmd_pkg::ST_IDLE;
                end
                default:
                begin
                    state <= cmd_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Data path of the output register and the captured fill word
    always_ff @(posedge aclk)
    begin
        if (state == cmd_pkg::ST_FILL_WORD && s_axis_tvalid)
            fill_q <= s_axis_tdata;

        if (load_stream || load_fill)
        begin
            fifo_in_word <= load_stream ? s_axis_tdata : fill_q;
            // The word that takes the counter from one to zero ends the command
            fifo_in_last <= (counter == 1);
        end
    end

endmodule

`default_nettype wire

// ==== pixel_unpacker.sv ====
// Pixel unpacker.
// Splits each buffered 32-bit word into RGB565 pixels on the output
// stream, low half first. tlast marks the final pixel of a last word.

`timescale 1ns/1ps
`default_nettype none

module pixel_unpacker (
    input  wire logic              aclk,
    input  wire logic              resetn,

    input  wire logic              word_valid,
    output logic                   word_ready,
    input  wire stream_pkg::word_t word_data,
    input  wire logic              word_last,

    output logic                   m_axis_tvalid,
    input  wire logic              m_axis_tready,
    output stream_pkg::pixel_t     m_axis_tdata,
    output logic                   m_axis_tlast
);

    localparam int PIX_W = $bits(stream_pkg::pixel_t);
    localparam int IDX_W = $clog2(stream_pkg::PIXELS_PER_WORD);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(stream_pkg::PIXELS_PER_WORD - 1);

    stream_pkg::word_t word_q;
    logic              last_q;
    logic [IDX_W-1:0]  pix_idx;

    logic pix_fire;
    logic final_pix;
    logic take;

    assign pix_fire  = m_axis_tvalid && m_axis_tready;
    assign final_pix = (pix_idx == LAST_IDX);

    // Refill as soon as the high half leaves, keeping one pixel per cycle
    assign word_ready = !m_axis_tvalid || (pix_fire && final_pix);
    assign take       = word_valid && word_ready;

    assign m_axis_tdata = word_q[pix_idx*PIX_W +: PIX_W];
    assign m_axis_tlast = last_q && final_pix;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            m_axis_tvalid <= 1'b0;
            pix_idx       <= '0;
        end
        else if (take)
        begin
            m_axis_tvalid <= 1'b1;
            pix_idx       <= '0;
        end
        else if (pix_fire)
        begin
            if (final_pix)
                m_axis_tvalid <= 1'b0;
            else
                pix_idx <= pix_idx + 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (take)
        begin
            word_q <= word_data;
            last_q <= word_last;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
stream_pkg.sv
cmd_pkg.sv
command_parser.sv
stream_fifo.sv
pixel_unpacker.sv
cmd_stream_top.sv
tb_cmd_stream.sv

// ==== stream_fifo.sv ====
// Synchronous FIFO for tagged stream words.
// Each entry keeps a word with its last flag. Full and empty follow from
// read and write pointers that carry one extra wrap bit.

`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic              aclk,
    input  wire logic              resetn,

    input  wire logic              in_valid,
    output logic                   in_ready,
    input  wire stream_pkg::word_t in_word,
    input  wire logic              in_last,

    output logic                   out_valid,
    input  wire logic              out_ready,
    output stream_pkg::word_t      out_word,
    output logic                   out_last
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    logic [stream_pkg::FIFO_ENTRY_WIDTH-1:0] mem [FIFO_DEPTH];

    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic empty;
    logic full;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    // Same slot, but the writer has wrapped once more than the reader
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    assign {out_last, out_word} = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (wr_en)
            mem[wr_ptr[ADDR_W-1:0]] <= {in_last, in_word};
    end

endmodule

`default_nettype wire

// ==== stream_pkg.sv ====
// Stream data definitions shared by the parser, the FIFO and the
// pixel unpacker.

`default_nettype none

package stream_pkg;

    // One word on the command and payload stream
    typedef logic [31:0] word_t;

    // One RGB565 pixel
    typedef logic [15:0] pixel_t;

    // Pixels packed into one stream word, low half first
    localparam int PIXELS_PER_WORD = 2;

    // A FIFO entry holds the word plus its last flag
    localparam int FIFO_ENTRY_WIDTH = $bits(word_t) + 1;

endpackage

`default_nettype wire

// ==== tb_cmd_model.svh ====
// Reference model and checker for the command stream testbench.
// Expected pixels and their tlast flags wait in order in two queues
// until the output monitor compares them with what the DUT sends.

`ifndef TB_CMD_MODEL_SVH
`define TB_CMD_MODEL_SVH

stream_pkg::pixel_t exp_pixel[$];
bit                 exp_last[$];
int                 error_count = 0;
int                 check_count = 0;

// Number of words that a command with this byte count moves
function automatic int beats_of(input cmd_pkg::byte_count_t bytes);
    return int'(bytes) / 4;
endfunction

// Compares one observed value with its expected value
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    check_count++;
    if (got !== expected)
    begin
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t",
                 name, got, expected, $time);
        error_count++;
    end
endtask

// Splits one payload word into its pixels, low half first
task automatic model_word(input stream_pkg::word_t word, input bit last);
    int p;
    for (p = 0; p < stream_pkg::PIXELS_PER_WORD; p++)
    begin
        exp_pixel.push_back(word[p*$bits(stream_pkg::pixel_t) +: $bits(stream_pkg::pixel_t)]);
        // Only the high half of the final word closes the command
        exp_last.push_back(last && (p == stream_pkg::PIXELS_PER_WORD - 1));
    end
endtask

task automatic check_pixel(input stream_pkg::pixel_t data, input logic last);
    if (exp_pixel.size() == 0)
    begin
        $display("Unexpected pixel 0x%0h on the output with nothing left in the model at %0t",
                 data, $time);
        error_count++;
    end
    else
    begin
        check_value("m_axis_tdata", data, exp_pixel.pop_front());
        check_value("m_axis_tlast", last, exp_last.pop_front());
    end
endtask

`endif

// ==== tb_cmd_stream.sv ====
// Testbench for the rasterizer command front end.
// Sends random STREAM, MEMSET and dropped commands, applies random
// back-pressure on the pixel output and checks every pixel in order
// against a reference model.

`timescale 1ns/1ps
`default_nettype none

module tb_cmd_stream;

    localparam int TIMEOUT_CYCLES = 2000;

    logic               aclk;
    logic               resetn;
    logic               s_axis_tvalid;
    logic               s_axis_tready;
    stream_pkg::word_t  s_axis_tdata;
    logic               m_axis_tvalid;
    logic               m_axis_tready;
    stream_pkg::pixel_t m_axis_tdata;
    logic               m_axis_tlast;

    bit random_ready;
    bit timed_out;
    int test_count;
    int failed_tests;
    int pixel_count;
    int seed_value;

    `include "tb_cmd_model.svh"

    cmd_stream_top #(
        .FIFO_DEPTH (8)
    ) dut (
        .aclk          (aclk),
        .resetn        (resetn),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .s_axis_tdata  (s_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

    always #2 aclk = ~aclk;

    // Output back-pressure, low about half the time when enabled
    always @(negedge aclk)
    begin
        m_axis_tready = random_ready ? (($urandom % 2) == 0) : 1'b1;
    end

    always @(posedge aclk)
    begin
        if (resetn && m_axis_tvalid && m_axis_tready)
        begin
            pixel_count++;
            check_pixel(m_axis_tdata, m_axis_tlast);
        end
    end

    function automatic stream_pkg::word_t make_cmd(input logic [3:0] op,
                                                   input cmd_pkg::byte_count_t bytes);
        stream_pkg::word_t cmd;
        cmd = '0;
        cmd[cmd_pkg::OP_POS +: cmd_pkg::OP_SIZE]   = op;
        cmd[cmd_pkg::IMM_POS +: cmd_pkg::IMM_SIZE] = bytes;
        return cmd;
    endfunction

    // Offers one word on the input stream and waits for the handshake
    task automatic send_word(input stream_pkg::word_t word);
        int waited;
        bit done;
        if (timed_out)
            return;
        waited = 0;
        done = 1'b0;
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = word;
        while (!done)
        begin
            @(posedge aclk);
            if (s_axis_tready)
                done = 1'b1;
            else if (waited == TIMEOUT_CYCLES)
            begin
                $display("Timeout: the DUT did not accept input word 0x%0h", word);
                timed_out = 1'b1;
                done = 1'b1;
            end
            waited++;
        end
        @(negedge aclk);
        s_axis_tvalid = 1'b0;
    endtask

    task automatic run_stream(input cmd_pkg::byte_count_t bytes);
        int beats;
        int i;
        stream_pkg::word_t word;
        beats = beats_of(bytes);
        send_word(make_cmd(cmd_pkg::OP_STREAM, bytes));
        for (i = 0; i < beats; i++)
        begin
            word = $urandom;
            send_word(word);
            model_word(word, i == beats - 1);
        end
    endtask

    task automatic run_memset(input cmd_pkg::byte_count_t bytes,
                              input stream_pkg::word_t fill);
        int beats;
        int i;
        beats = beats_of(bytes);
        send_word(make_cmd(cmd_pkg::OP_MEMSET, bytes));
        // A count below one word reads no fill word
        if (beats > 0)
        begin
            send_word(fill);
            for (i = 0; i < beats; i++)
                model_word(fill, i == beats - 1);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_pixel.size() != 0 && waited < TIMEOUT_CYCLES)
        begin
            @(negedge aclk);
            waited++;
        end
        if (exp_pixel.size() != 0)
        begin
            $display("Timeout: %0d expected pixels never left the DUT", exp_pixel.size());
            timed_out = 1'b1;
        end
        // Quiet cycles so that any extra pixel still reaches the monitor
        repeat (20) @(negedge aclk);
    endtask

    task automatic end_test(input string name, input int errors_before);
        wait_drain();
        test_count++;
        if (error_count != errors_before || timed_out)
        begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
        else
            $display("%s: ok", name);
    endtask

    initial
    begin : main_seq
        int errors_before;
        int i;
        int n;
        logic [3:0] op;
        seed_value = $urandom(58401);
        aclk = 1'b0;
        resetn = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata = '0;
        m_axis_tready = 1'b0;
        random_ready = 1'b0;
        timed_out = 1'b0;
        repeat (16) @(negedge aclk);
        resetn = 1'b1;

        errors_before = error_count;
        check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
        n = 0;
        while (!s_axis_tready && n < 16)
        begin
            @(negedge aclk);
            n++;
        end
        if (!s_axis_tready)
        begin
            $display("s_axis_tready did not rise within 16 cycles after reset");
            error_count++;
            timed_out = 1'b1;
        end
        end_test("test 1 reset", errors_before);

        errors_before = error_count;
        for (i = 0; i < 12; i++)
            run_stream(cmd_pkg::byte_count_t'(4 + $urandom % 61));
        end_test("test 2 stream", errors_before);

        errors_before = error_count;
        for (i = 0; i < 8; i++)
            run_memset(cmd_pkg::byte_count_t'(4 + $urandom % 61), $urandom);
        end_test("test 3 memset", errors_before);

        errors_before = error_count;
        send_word(make_cmd(cmd_pkg::OP_NOP, 16));
        send_word(make_cmd(cmd_pkg::OP_STORE, 8));
        send_word(make_cmd(cmd_pkg::OP_LOAD, 12));
        for (i = 0; i < 4; i++)
            send_word(make_cmd(4'(5 + $urandom % 11), cmd_pkg::byte_count_t'($urandom % 64)));
        run_stream(cmd_pkg::byte_count_t'($urandom % 4));
        run_memset(cmd_pkg::byte_count_t'($urandom % 4), $urandom);
        run_stream(16);
        end_test("test 4 dropped commands", errors_before);

        errors_before = error_count;
        random_ready = 1'b1;
        for (i = 0; i < 40; i++)
        begin
            n = $urandom % 4;
            if (n < 2)
                run_stream(cmd_pkg::byte_count_t'(4 + $urandom % 61));
            else if (n == 2)
                run_memset(cmd_pkg::byte_count_t'(4 + $urandom % 61), $urandom);
            else
            begin
                op = $urandom % 16;
                if (op == cmd_pkg::OP_MEMSET || op == cmd_pkg::OP_STREAM)
                    op = cmd_pkg::OP_NOP;
                send_word(make_cmd(op, cmd_pkg::byte_count_t'($urandom % 64)));
            end
            repeat ($urandom % 3) @(negedge aclk);
        end
        end_test("test 5 back-pressure mix", errors_before);
        random_ready = 1'b0;

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d pixels",
                 test_count, failed_tests, check_count, error_count, pixel_count);
        if (error_count == 0 && failed_tests == 0 && !timed_out)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
